// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mps
RTL_TOP ?= mps_wrapper
FILELIST ?= mps.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS ?= mps_pkg.sv mps_uart_port.sv mps_host_target.sv mps_core.sv mps_wrapper.sv

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: mps.f
+incdir+.
mps_pkg.sv
mps_uart_port.sv
mps_host_target.sv
mps_core.sv
mps_wrapper.sv
tb_mps.sv

// File: mps_consts.svh
`ifndef MPS_CONSTS_SVH
`define MPS_CONSTS_SVH

// bus word width and decoded address window
`define MPS_DATA_W    32
`define MPS_ADDR_BITS 8
`define MPS_CHAN_W    3

// byte offsets inside the 16-byte window of one channel
`define MPS_REG_DATA   4'h0
`define MPS_REG_STATUS 4'h4
`define MPS_REG_CTRL   4'h8
`define MPS_REG_DIV    4'hC

// global pending word, one bit per channel
`define MPS_REG_IRQ 8'h80

// cycles the internal reset is held after RST falls
`define MPS_RST_HOLD 64

// bit time in CLK cycles
`define MPS_DIV_W     16
`define MPS_DIV_RESET 16

`endif

// File: mps_core.sv
`timescale 1ns/100ps
`include "mps_consts.svh"

module mps_core #(
	parameter int PORT_NUM = 4
) (
	input  logic                     CLK,
	input  logic                     RST,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  logic                     req_write,
	input  logic [`MPS_CHAN_W-1:0]   req_chan,
	input  mps_pkg::reg_sel_e        req_sel,
	input  logic                     req_irq,
	input  logic [`MPS_DATA_W-1:0]   req_wdata,
	output logic                     rsp_valid,
	output logic [`MPS_DATA_W-1:0]   rsp_rdata,
	output logic                     irq,
	input  logic [PORT_NUM-1:0]      rxd,
	input  logic [PORT_NUM-1:0]      ctsn,
	input  logic [PORT_NUM-1:0]      dsrn,
	input  logic [PORT_NUM-1:0]      ri,
	input  logic [PORT_NUM-1:0]      dcdn,
	output logic [PORT_NUM-1:0]      txd,
	output logic [PORT_NUM-1:0]      rtsn,
	output logic [PORT_NUM-1:0]      dtrn
);

	logic [PORT_NUM-1:0] chan_dec;
	logic [PORT_NUM-1:0] tx_start, tx_busy, rx_pop, rx_valid, rx_overrun, ovr_vis;
	logic [PORT_NUM-1:0] rx_irq_en, irq_bits;
	logic [PORT_NUM-1:0] cts, dsr, ri_st, dcd;
	logic [7:0] rx_byte [PORT_NUM];
	logic [2:0] ctrl_all [PORT_NUM];
	logic [`MPS_DIV_W-1:0] div_all [PORT_NUM];
	logic [`MPS_DATA_W-1:0] rd_data;
	logic xfer;

	// a DATA write waits while the addressed shifter is still sending
	assign req_ready = !(req_valid && req_write && (req_sel == mps_pkg::SEL_DATA) &&
		|(chan_dec & tx_busy));
	assign xfer = req_valid && req_ready;

	assign irq_bits = rx_valid & rx_irq_en;
	assign irq = |irq_bits;

	for (genvar i = 0; i < PORT_NUM; i++) begin : g_chan
		logic rts_q, dtr_q, en_q, ovr_mask;
		logic [`MPS_DIV_W-1:0] div_q;
		logic wr_hit, rd_hit;

		assign chan_dec[i] = !req_irq && (req_chan == i);
		assign wr_hit = xfer && req_write && chan_dec[i];
		assign rd_hit = xfer && !req_write && chan_dec[i];
		assign tx_start[i] = wr_hit && (req_sel == mps_pkg::SEL_DATA);
		assign rx_pop[i] = rd_hit && (req_sel == mps_pkg::SEL_DATA);

		assign rx_irq_en[i] = en_q;
		assign ctrl_all[i] = {en_q, dtr_q, rts_q};
		assign div_all[i] = div_q;
		assign ovr_vis[i] = rx_overrun[i] && !ovr_mask;

		always_ff @(posedge CLK or posedge RST) begin
			if (RST) begin
				rts_q <= 1'b0;
				dtr_q <= 1'b0;
				en_q <= 1'b0;
				ovr_mask <= 1'b0;
				div_q <= `MPS_DIV_W'(`MPS_DIV_RESET);
			end else begin
				if (wr_hit && (req_sel == mps_pkg::SEL_CTRL)) begin
					rts_q <= req_wdata[0];
					dtr_q <= req_wdata[1];
					en_q <= req_wdata[2];
				end
				if (wr_hit && (req_sel == mps_pkg::SEL_DIV)) begin
					div_q <= req_wdata[`MPS_DIV_W-1:0];
				end
				// a STATUS read hides the overrun until the port drops it
				if (!rx_overrun[i]) begin
					ovr_mask <= 1'b0;
				end else if (rd_hit && (req_sel == mps_pkg::SEL_STATUS)) begin
					ovr_mask <= 1'b1;
				end
			end
		end

		mps_uart_port u_port (
			.CLK        (CLK),
			.RST        (RST),
			.tx_start   (tx_start[i]),
			.tx_byte    (req_wdata[7:0]),
			.divisor    (div_q),
			.rts        (rts_q),
			.dtr        (dtr_q),
			.rx_pop     (rx_pop[i]),
			.rxd        (rxd[i]),
			.ctsn       (ctsn[i]),
			.dsrn       (dsrn[i]),
			.ri         (ri[i]),
			.dcdn       (dcdn[i]),
			.tx_busy    (tx_busy[i]),
			.rx_byte    (rx_byte[i]),
			.rx_valid   (rx_valid[i]),
			.rx_overrun (rx_overrun[i]),
			.cts        (cts[i]),
			.dsr        (dsr[i]),
			.ri_out     (ri_st[i]),
			.dcd        (dcd[i]),
			.txd        (txd[i]),
			.rtsn       (rtsn[i]),
			.dtrn       (dtrn[i])
		);
	end

	// STATUS layout: rx_valid, overrun, tx_busy, spare, cts, dsr, ri, dcd
	always_comb begin
		rd_data = '0;
		if (req_irq) begin
			rd_data[PORT_NUM-1:0] = irq_bits;
		end
		for (int i = 0; i < PORT_NUM; i++) begin
			if (chan_dec[i]) begin
				case (req_sel)
					mps_pkg::SEL_DATA:   rd_data[7:0] = rx_byte[i];
					mps_pkg::SEL_STATUS: rd_data[7:0] = {dcd[i], ri_st[i], dsr[i], cts[i],
						1'b0, tx_busy[i], ovr_vis[i], rx_valid[i]};
					mps_pkg::SEL_CTRL:   rd_data[2:0] = ctrl_all[i];
					mps_pkg::SEL_DIV:    rd_data[`MPS_DIV_W-1:0] = div_all[i];
					default:             rd_data = '0;
				endcase
			end
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= xfer;
		end
	end

	always_ff @(posedge CLK) begin
		rsp_rdata <= req_write ? '0 : rd_data;
	end

endmodule

// File: mps_host_target.sv
`timescale 1ns/100ps
`include "mps_consts.svh"

module mps_host_target (
	input  logic                     CLK,
	input  logic                     RST,
	input  logic [`MPS_DATA_W-1:0]   ADDR,
	input  logic                     ADDR_VLD,
	input  logic [7:0]               BASE_HIT,
	input  logic                     S_WRDN,
	input  logic                     S_DATA_VLD,
	input  logic [`MPS_DATA_W-1:0]   ADIO_OUT,
	output logic [`MPS_DATA_W-1:0]   ADIO_IN,
	output logic                     S_READY,
	output logic                     S_TERM,
	output logic                     req_valid,
	output logic                     req_write,
	output logic [`MPS_CHAN_W-1:0]   req_chan,
	output mps_pkg::reg_sel_e        req_sel,
	output logic                     req_irq,
	output logic [`MPS_DATA_W-1:0]   req_wdata,
	input  logic                     req_ready,
	input  logic                     rsp_valid,
	input  logic [`MPS_DATA_W-1:0]   rsp_rdata
);

	mps_pkg::tgt_state_e state;
	mps_pkg::reg_sel_e dec_sel;
	logic [`MPS_CHAN_W-1:0] dec_chan;
	logic dec_irq;
	logic claim;

	// only BAR 0 belongs to this card
	assign claim = (state == mps_pkg::TGT_IDLE) && ADDR_VLD && BASE_HIT[0];

	// channel n occupies offsets n*16 to n*16+15 below the IRQ word
	always_comb begin
		dec_chan = ADDR[`MPS_CHAN_W+3:4];
		dec_irq = 1'b0;
		dec_sel = mps_pkg::SEL_NONE;
		if (ADDR[`MPS_ADDR_BITS-1:0] == `MPS_REG_IRQ) begin
			dec_irq = 1'b1;
		end else if (!ADDR[`MPS_ADDR_BITS-1]) begin
			case (ADDR[3:0])
				`MPS_REG_DATA:   dec_sel = mps_pkg::SEL_DATA;
				`MPS_REG_STATUS: dec_sel = mps_pkg::SEL_STATUS;
				`MPS_REG_CTRL:   dec_sel = mps_pkg::SEL_CTRL;
				`MPS_REG_DIV:    dec_sel = mps_pkg::SEL_DIV;
				default:         dec_sel = mps_pkg::SEL_NONE;
			endcase
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= mps_pkg::TGT_IDLE;
			req_valid <= 1'b0;
			S_READY <= 1'b0;
			S_TERM <= 1'b0;
			ADIO_IN <= '0;
		end else begin
			S_READY <= 1'b0;
			S_TERM <= 1'b0;
			ADIO_IN <= '0;
			case (state)
				mps_pkg::TGT_IDLE: begin
					if (claim) begin
						state <= mps_pkg::TGT_WAIT_DATA;
					end
				end
				mps_pkg::TGT_WAIT_DATA: begin
					if (S_DATA_VLD) begin
						req_valid <= 1'b1;
						state <= mps_pkg::TGT_REQ;
					end
				end
				mps_pkg::TGT_REQ: begin
					// transmit back-pressure can hold the request here for a whole frame
					if (req_ready) begin
						req_valid <= 1'b0;
						state <= mps_pkg::TGT_DONE;
					end
				end
				mps_pkg::TGT_DONE: begin
					// the core already returns zero for writes
					if (rsp_valid) begin
						S_READY <= 1'b1;
						S_TERM <= 1'b1;
						ADIO_IN <= rsp_rdata;
						state <= mps_pkg::TGT_IDLE;
					end
				end
				default: state <= mps_pkg::TGT_IDLE;
			endcase
		end
	end

	// request fields stay stable from claim until the transfer
	always_ff @(posedge CLK) begin
		if (claim) begin
			req_write <= S_WRDN;
			req_chan <= dec_chan;
			req_sel <= dec_sel;
			req_irq <= dec_irq;
		end
		if ((state == mps_pkg::TGT_WAIT_DATA) && S_DATA_VLD) begin
			req_wdata <= ADIO_OUT;
		end
	end

endmodule

// File: mps_pkg.sv
package mps_pkg;

	// register selected inside one channel window
	typedef enum logic [2:0] {
		SEL_DATA   = 3'd0,
		SEL_STATUS = 3'd1,
		SEL_CTRL   = 3'd2,
		SEL_DIV    = 3'd3,
		SEL_NONE   = 3'd4
	} reg_sel_e;

	// bus target phases
	typedef enum logic [1:0] {
		TGT_IDLE,
		TGT_WAIT_DATA,
		TGT_REQ,
		TGT_DONE
	} tgt_state_e;

	// serial shifter phases, shared by transmit and receive
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_BITS,
		UART_STOP
	} uart_state_e;

endpackage

// File: mps_uart_port.sv
`timescale 1ns/100ps
`include "mps_consts.svh"

module mps_uart_port (
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   tx_start,
	input  logic [7:0]             tx_byte,
	input  logic [`MPS_DIV_W-1:0]  divisor,
	input  logic                   rts,
	input  logic                   dtr,
	input  logic                   rx_pop,
	input  logic                   rxd,
	input  logic                   ctsn,
	input  logic                   dsrn,
	input  logic                   ri,
	input  logic                   dcdn,
	output logic                   tx_busy,
	output logic [7:0]             rx_byte,
	output logic                   rx_valid,
	output logic                   rx_overrun,
	output logic                   cts,
	output logic                   dsr,
	output logic                   ri_out,
	output logic                   dcd,
	output logic                   txd,
	output logic                   rtsn,
	output logic                   dtrn
);

	// idle levels of {dcdn, ri, dsrn, ctsn, rxd}
	localparam logic [4:0] SYNC_IDLE = 5'b10111;

	logic [4:0] sync1, sync2;
	logic rxd_s, rxd_prev;
	mps_pkg::uart_state_e tx_state, rx_state;
	logic [`MPS_DIV_W-1:0] tx_cnt, rx_cnt;
	logic [2:0] tx_bit, rx_bit;
	logic [7:0] tx_shift, rx_shift;
	logic tx_end, tx_shift_en, rx_end, rx_sample, rx_load;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			sync1 <= SYNC_IDLE;
			sync2 <= SYNC_IDLE;
			rxd_prev <= 1'b1;
		end else begin
			sync1 <= {dcdn, ri, dsrn, ctsn, rxd};
			sync2 <= sync1;
			rxd_prev <= rxd_s;
		end
	end

	assign rxd_s = sync2[0];
	assign cts = !sync2[1];
	assign dsr = !sync2[2];
	assign ri_out = sync2[3];
	assign dcd = !sync2[4];
	assign rtsn = !rts;
	assign dtrn = !dtr;

	assign tx_busy = (tx_state != mps_pkg::UART_IDLE);
	assign tx_end = (tx_cnt == divisor - 16'd1);
	assign tx_shift_en = tx_end && ((tx_state == mps_pkg::UART_START) ||
		((tx_state == mps_pkg::UART_BITS) && (tx_bit != 3'd7)));

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			tx_state <= mps_pkg::UART_IDLE;
			tx_cnt <= '0;
			tx_bit <= '0;
			txd <= 1'b1;
		end else if (tx_state == mps_pkg::UART_IDLE) begin
			tx_cnt <= '0;
			if (tx_start) begin
				txd <= 1'b0;
				tx_state <= mps_pkg::UART_START;
			end
		end else begin
			tx_cnt <= tx_end ? '0 : tx_cnt + 16'd1;
			if (tx_shift_en) begin
				txd <= tx_shift[0];
			end
			if (tx_end) begin
				case (tx_state)
					mps_pkg::UART_START: begin
						tx_bit <= '0;
						tx_state <= mps_pkg::UART_BITS;
					end
					mps_pkg::UART_BITS: begin
						tx_bit <= tx_bit + 3'd1;
						if (tx_bit == 3'd7) begin
							txd <= 1'b1;
							tx_state <= mps_pkg::UART_STOP;
						end
					end
					default: tx_state <= mps_pkg::UART_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge CLK) begin
		if ((tx_state == mps_pkg::UART_IDLE) && tx_start) begin
			tx_shift <= tx_byte;
		end else if (tx_shift_en) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end
	end

	// rx_cnt restarts at the middle of the start bit, so later ticks land mid-bit
	assign rx_end = (rx_cnt == divisor - 16'd1);
	assign rx_sample = rx_end && (rx_state == mps_pkg::UART_BITS);
	assign rx_load = rx_end && (rx_state == mps_pkg::UART_STOP) && (!rx_valid || rx_pop);

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			rx_state <= mps_pkg::UART_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
			rx_overrun <= 1'b0;
		end else begin
			if (rx_pop) begin
				rx_valid <= 1'b0;
				rx_overrun <= 1'b0;
			end
			case (rx_state)
				mps_pkg::UART_IDLE: begin
					rx_cnt <= 16'd1;
					if (rxd_prev && !rxd_s) begin
						rx_state <= mps_pkg::UART_START;
					end
				end
				mps_pkg::UART_START: begin
					rx_cnt <= rx_cnt + 16'd1;
					if (rx_cnt >= {1'b0, divisor[`MPS_DIV_W-1:1]}) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						// a start bit that is gone by mid-bit was a glitch
						rx_state <= rxd_s ? mps_pkg::UART_IDLE : mps_pkg::UART_BITS;
					end
				end
				mps_pkg::UART_BITS: begin
					rx_cnt <= rx_end ? '0 : rx_cnt + 16'd1;
					if (rx_end) begin
						rx_bit <= rx_bit + 3'd1;
						if (rx_bit == 3'd7) begin
							rx_state <= mps_pkg::UART_STOP;
						end
					end
				end
				default: begin
					rx_cnt <= rx_end ? '0 : rx_cnt + 16'd1;
					if (rx_end) begin
						rx_state <= mps_pkg::UART_IDLE;
						if (rx_load) begin
							rx_valid <= 1'b1;
						end else begin
							rx_overrun <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (rx_sample) begin
			rx_shift <= {rxd_s, rx_shift[7:1]};
		end
		if (rx_load) begin
			rx_byte <= rx_shift;
		end
	end

endmodule

// File: mps_wrapper.sv
`timescale 1ns/100ps
`include "mps_consts.svh"

module mps_wrapper #(
	parameter int PORT_NUM = 4
) (
	input  logic                     CLK,
	input  logic                     RST,
	input  logic [`MPS_DATA_W-1:0]   ADDR,
	input  logic                     ADDR_VLD,
	input  logic [7:0]               BASE_HIT,
	input  logic                     S_WRDN,
	input  logic                     S_DATA_VLD,
	input  logic [`MPS_DATA_W-1:0]   ADIO_OUT,
	output logic [`MPS_DATA_W-1:0]   ADIO_IN,
	output logic                     S_READY,
	output logic                     S_TERM,
	output logic                     INT_N,
	input  logic [PORT_NUM-1:0]      rxd,
	input  logic [PORT_NUM-1:0]      ctsn,
	input  logic [PORT_NUM-1:0]      dsrn,
	input  logic [PORT_NUM-1:0]      ri,
	input  logic [PORT_NUM-1:0]      dcdn,
	output logic [PORT_NUM-1:0]      txd,
	output logic [PORT_NUM-1:0]      rtsn,
	output logic [PORT_NUM-1:0]      dtrn
);

	localparam int CNT_W = $clog2(`MPS_RST_HOLD + 1);

	logic [CNT_W-1:0] rst_cnt;
	logic int_rst;
	logic req_valid, req_ready, req_write, req_irq, rsp_valid, irq;
	logic [`MPS_CHAN_W-1:0] req_chan;
	mps_pkg::reg_sel_e req_sel;
	logic [`MPS_DATA_W-1:0] req_wdata, rsp_rdata;

	// internal reset is held for a fixed count after RST is released
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			rst_cnt <= '0;
			int_rst <= 1'b1;
		end else if (int_rst) begin
			rst_cnt <= rst_cnt + 1'b1;
			if (rst_cnt == CNT_W'(`MPS_RST_HOLD - 1)) begin
				int_rst <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK or posedge int_rst) begin
		if (int_rst) begin
			INT_N <= 1'b1;
		end else begin
			INT_N <= !irq;
		end
	end

	mps_host_target u_target (
		.CLK(CLK), .RST(int_rst), .ADDR(ADDR), .ADDR_VLD(ADDR_VLD), .BASE_HIT(BASE_HIT),
		.S_WRDN(S_WRDN), .S_DATA_VLD(S_DATA_VLD), .ADIO_OUT(ADIO_OUT), .ADIO_IN(ADIO_IN),
		.S_READY(S_READY), .S_TERM(S_TERM), .req_valid(req_valid), .req_write(req_write),
		.req_chan(req_chan), .req_sel(req_sel), .req_irq(req_irq), .req_wdata(req_wdata),
		.req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata)
	);

	mps_core #(.PORT_NUM(PORT_NUM)) u_core (
		.CLK(CLK), .RST(int_rst), .req_valid(req_valid), .req_ready(req_ready),
		.req_write(req_write), .req_chan(req_chan), .req_sel(req_sel), .req_irq(req_irq),
		.req_wdata(req_wdata), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .irq(irq),
		.rxd(rxd), .ctsn(ctsn), .dsrn(dsrn), .ri(ri), .dcdn(dcdn),
		.txd(txd), .rtsn(rtsn), .dtrn(dtrn)
	);

endmodule

// File: tb_mps.sv
`timescale 1ns/100ps
`include "mps_consts.svh"

module tb_mps;

	localparam int PORT_NUM = 4;
	// frame cycles of tests 2, 3, 4 and 6 at their divisors
	localparam int FRAME_CYCLES = 10 * (2 * 8 + 2 * 10 + 2 * 8 + 8 + 11 + 14 + 17);
	localparam real WATCHDOG_NS = 4.0 * (2 * FRAME_CYCLES + 3000);

	logic CLK;
	logic RST;
	logic [31:0] ADDR;
	logic ADDR_VLD;
	logic [7:0] BASE_HIT;
	logic S_WRDN;
	logic S_DATA_VLD;
	logic [31:0] ADIO_OUT;
	logic [31:0] ADIO_IN;
	logic S_READY;
	logic S_TERM;
	logic INT_N;
	logic [PORT_NUM-1:0] rxd_drv, ctsn, dsrn, ri, dcdn;
	logic [PORT_NUM-1:0] txd, rtsn, dtrn;
	wire [PORT_NUM-1:0] rxd;
	logic loopback, watch_idle, idle_bad, watch_int, int_low_seen;
	logic [31:0] lfsr;
	int errors, checks, tests_run, tests_failed, errors_before;

	assign rxd = loopback ? txd : rxd_drv;

	mps_wrapper #(.PORT_NUM(PORT_NUM)) DUT (
		.CLK(CLK), .RST(RST), .ADDR(ADDR), .ADDR_VLD(ADDR_VLD), .BASE_HIT(BASE_HIT),
		.S_WRDN(S_WRDN), .S_DATA_VLD(S_DATA_VLD), .ADIO_OUT(ADIO_OUT), .ADIO_IN(ADIO_IN),
		.S_READY(S_READY), .S_TERM(S_TERM), .INT_N(INT_N), .rxd(rxd), .ctsn(ctsn),
		.dsrn(dsrn), .ri(ri), .dcdn(dcdn), .txd(txd), .rtsn(rtsn), .dtrn(dtrn)
	);

	always #2 CLK = ~CLK;

	// sticky monitors, sampled away from the rising edge
	always @(negedge CLK) begin
		if (watch_idle && ((txd & 4'b1011) != 4'b1011)) begin
			idle_bad = 1'b1;
		end
		if (watch_int && !INT_N) begin
			int_low_seen = 1'b1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the tests did not finish in time", $time);
		$display("TEST FAILED");
		$finish;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	function automatic logic [31:0] reg_addr(input int ch, input logic [3:0] off);
		return 32'(ch * 16) + 32'(off);
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] want, input string msg);
		checks++;
		assert (got === want) else begin
			$display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, msg, got, want);
			errors++;
		end
	endtask

	task automatic open_test();
		errors_before = errors;
		tests_run++;
	endtask

	task automatic close_test(input string name);
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	task automatic bus_transfer(input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output realtime t_ready);
		@(posedge CLK);
		#0.5;
		ADDR = addr;
		ADDR_VLD = 1'b1;
		BASE_HIT = 8'h01;
		S_WRDN = write;
		@(posedge CLK);
		#0.5;
		ADDR_VLD = 1'b0;
		BASE_HIT = 8'h00;
		S_DATA_VLD = 1'b1;
		ADIO_OUT = write ? wdata : 32'h0;
		// the data phase lasts until the card terminates it
		while (!S_READY) begin
			@(posedge CLK);
			#0.5;
		end
		check(32'(S_TERM), 32'd1, "S_TERM together with S_READY");
		if (write) begin
			check(ADIO_IN, 32'h0, "ADIO_IN during a write");
		end
		rdata = ADIO_IN;
		t_ready = $realtime;
		S_DATA_VLD = 1'b0;
		ADIO_OUT = 32'h0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] unused_rd;
		realtime unused_t;
		bus_transfer(1'b1, addr, wdata, unused_rd, unused_t);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
		realtime unused_t;
		bus_transfer(1'b0, addr, 32'h0, rdata, unused_t);
	endtask

	task automatic send_frame(input int ch, input int div, input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		@(posedge CLK);
		#0.5;
		for (int b = 0; b < 10; b++) begin
			rxd_drv[ch] = frame[b];
			repeat (div) @(posedge CLK);
			#0.5;
		end
	endtask

	// txd falls on a rising edge and is first seen at the falling edge after it
	task automatic capture_frame(input int ch, input int div, output logic [7:0] data,
			output realtime t_start);
		@(negedge CLK);
		while (txd[ch] !== 1'b0) begin
			@(negedge CLK);
		end
		t_start = $realtime - 2.0;
		repeat (div / 2) @(negedge CLK);
		check(32'(txd[ch]), 32'd0, "start bit level");
		for (int b = 0; b < 8; b++) begin
			repeat (div) @(negedge CLK);
			data[b] = txd[ch];
		end
		repeat (div) @(negedge CLK);
		check(32'(txd[ch]), 32'd1, "stop bit level");
	endtask

	task automatic wait_rx(input int ch);
		logic [31:0] st;
		int tries;
		st = 32'h0;
		tries = 0;
		while (!st[0] && tries < 200) begin
			bus_read(reg_addr(ch, `MPS_REG_STATUS), st);
			tries++;
		end
		if (!st[0]) begin
			$display("channel %0d showed no received byte after %0d status reads", ch, tries);
			errors++;
		end
	endtask

	task automatic ctrl_div_readback();
		logic [31:0] ctrl_w [PORT_NUM];
		logic [31:0] div_w [PORT_NUM];
		logic [31:0] holes [4] = '{32'h40, 32'h74, 32'h84, 32'hF0};
		logic [31:0] rd;
		logic [7:0] b1, b2;
		open_test();
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			rand_byte(b1);
			rand_byte(b2);
			ctrl_w[ch] = {b2, b1, b2, b1};
			div_w[ch] = {b1, b2, b1, b2};
			bus_write(reg_addr(ch, `MPS_REG_CTRL), ctrl_w[ch]);
			bus_write(reg_addr(ch, `MPS_REG_DIV), div_w[ch]);
		end
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			bus_read(reg_addr(ch, `MPS_REG_CTRL), rd);
			check(rd, ctrl_w[ch] & 32'h7, $sformatf("channel %0d CTRL", ch));
			bus_read(reg_addr(ch, `MPS_REG_DIV), rd);
			check(rd, div_w[ch] & 32'hFFFF, $sformatf("channel %0d DIV", ch));
			check(32'(rtsn[ch]), 32'(!ctrl_w[ch][0]), $sformatf("channel %0d rtsn", ch));
			check(32'(dtrn[ch]), 32'(!ctrl_w[ch][1]), $sformatf("channel %0d dtrn", ch));
		end
		for (int h = 0; h < 4; h++) begin
			bus_read(holes[h], rd);
			check(rd, 32'h0, $sformatf("unmapped offset %0h", holes[h]));
		end
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			bus_write(reg_addr(ch, `MPS_REG_CTRL), 32'h0);
		end
		close_test("ctrl_div_readback");
	endtask

	task automatic transmit_backpressure();
		logic [7:0] b1, b2, got1, got2;
		logic [31:0] rd;
		realtime t1, t2, t_ready;
		open_test();
		bus_write(reg_addr(2, `MPS_REG_DIV), 32'd8);
		rand_byte(b1);
		rand_byte(b2);
		idle_bad = 1'b0;
		watch_idle = 1'b1;
		fork
			begin
				capture_frame(2, 8, got1, t1);
				capture_frame(2, 8, got2, t2);
			end
			begin
				bus_write(reg_addr(2, `MPS_REG_DATA), {24'h0, b1});
				bus_transfer(1'b1, reg_addr(2, `MPS_REG_DATA), {24'h0, b2}, rd, t_ready);
			end
		join
		watch_idle = 1'b0;
		check(32'(got1), 32'(b1), "first byte on txd[2]");
		check(32'(got2), 32'(b2), "second byte on txd[2]");
		check(32'(idle_bad), 32'd0, "other txd pins idle during the frames");
		checks++;
		// ten bits of 8 cycles at 4 ns each
		assert (t_ready >= t1 + 320.0) else begin
			$display("CHECK FAILED at %0t: second DATA write ended at %0t, frame began at %0t",
				$time, t_ready, t1);
			errors++;
		end
		close_test("transmit_backpressure");
	endtask

	task automatic receive_interrupt();
		logic [7:0] b;
		logic [31:0] rd;
		open_test();
		bus_write(reg_addr(1, `MPS_REG_DIV), 32'd10);
		bus_write(reg_addr(1, `MPS_REG_CTRL), 32'h4);
		check(32'(INT_N), 32'd1, "INT_N idle before the frame");
		rand_byte(b);
		send_frame(1, 10, b);
		wait_rx(1);
		bus_read(32'(`MPS_REG_IRQ), rd);
		check(rd, 32'h2, "IRQ word with channel 1 pending");
		check(32'(INT_N), 32'd0, "INT_N while channel 1 is pending");
		bus_read(reg_addr(1, `MPS_REG_DATA), rd);
		check(rd, {24'h0, b}, "channel 1 received byte");
		check(32'(INT_N), 32'd1, "INT_N after the DATA read");
		bus_write(reg_addr(1, `MPS_REG_CTRL), 32'h0);
		int_low_seen = 1'b0;
		watch_int = 1'b1;
		rand_byte(b);
		send_frame(1, 10, b);
		wait_rx(1);
		bus_read(32'(`MPS_REG_IRQ), rd);
		watch_int = 1'b0;
		check(rd, 32'h0, "IRQ word with rx_irq_en clear");
		check(32'(int_low_seen), 32'd0, "INT_N stayed high with rx_irq_en clear");
		bus_read(reg_addr(1, `MPS_REG_DATA), rd);
		check(rd, {24'h0, b}, "channel 1 byte without interrupt");
		close_test("receive_interrupt");
	endtask

	task automatic receive_overrun();
		logic [7:0] b1, b2;
		logic [31:0] rd;
		open_test();
		bus_write(reg_addr(0, `MPS_REG_DIV), 32'd8);
		rand_byte(b1);
		rand_byte(b2);
		send_frame(0, 8, b1);
		send_frame(0, 8, b2);
		repeat (4) @(posedge CLK);
		bus_read(reg_addr(0, `MPS_REG_STATUS), rd);
		check(32'(rd[1:0]), 32'h3, "STATUS valid and overrun");
		bus_read(reg_addr(0, `MPS_REG_STATUS), rd);
		check(32'(rd[1:0]), 32'h1, "overrun cleared by the STATUS read");
		bus_read(reg_addr(0, `MPS_REG_DATA), rd);
		check(rd, {24'h0, b1}, "first byte kept");
		bus_read(reg_addr(0, `MPS_REG_STATUS), rd);
		check(32'(rd[1:0]), 32'h0, "STATUS empty after the DATA read");
		close_test("receive_overrun");
	endtask

	task automatic modem_status();
		logic [7:0] lo, hi;
		logic [31:0] rd;
		logic [3:0] want;
		open_test();
		for (int k = 0; k < 4; k++) begin
			rand_byte(lo);
			rand_byte(hi);
			@(posedge CLK);
			#0.5;
			ctsn = lo[3:0];
			dsrn = lo[7:4];
			ri = hi[3:0];
			dcdn = hi[7:4];
			repeat (3) @(posedge CLK);
			for (int ch = 0; ch < PORT_NUM; ch++) begin
				want = {!dcdn[ch], ri[ch], !dsrn[ch], !ctsn[ch]};
				bus_read(reg_addr(ch, `MPS_REG_STATUS), rd);
				check(32'(rd[7:4]), 32'(want), $sformatf("channel %0d modem lines", ch));
			end
		end
		ctsn = '1;
		dsrn = '1;
		ri = '0;
		dcdn = '1;
		close_test("modem_status");
	endtask

	task automatic loopback_all();
		int divs [PORT_NUM] = '{8, 11, 14, 17};
		logic [7:0] bytes [PORT_NUM];
		logic [31:0] rd;
		open_test();
		loopback = 1'b1;
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			bus_write(reg_addr(ch, `MPS_REG_DIV), 32'(divs[ch]));
		end
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			rand_byte(bytes[ch]);
			bus_write(reg_addr(ch, `MPS_REG_DATA), {24'h0, bytes[ch]});
		end
		for (int ch = 0; ch < PORT_NUM; ch++) begin
			wait_rx(ch);
			bus_read(reg_addr(ch, `MPS_REG_DATA), rd);
			check(rd, {24'h0, bytes[ch]}, $sformatf("channel %0d looped byte", ch));
		end
		loopback = 1'b0;
		close_test("loopback_all");
	endtask

	initial begin
		CLK = 1'b0;
		RST = 1'b1;
		ADDR = 32'h0;
		ADDR_VLD = 1'b0;
		BASE_HIT = 8'h00;
		S_WRDN = 1'b0;
		S_DATA_VLD = 1'b0;
		ADIO_OUT = 32'h0;
		rxd_drv = '1;
		ctsn = '1;
		dsrn = '1;
		ri = '0;
		dcdn = '1;
		loopback = 1'b0;
		watch_idle = 1'b0;
		idle_bad = 1'b0;
		watch_int = 1'b0;
		int_low_seen = 1'b0;
		lfsr = 32'h6f4d;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(posedge CLK);
		#0.5;
		RST = 1'b0;
		repeat (`MPS_RST_HOLD) @(posedge CLK);
		ctrl_div_readback();
		transmit_backpressure();
		receive_interrupt();
		receive_overrun();
		modem_status();
		loopback_all();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
